// File: design/exec_pkg.sv
`default_nettype none

package exec_pkg;

	//////////////////////////////////////////////////
	// Sizes and latencies
	//////////////////////////////////////////////////

	localparam int data_width  = 32;
	localparam int fifo_depth  = 4;
	localparam int mult_cycles = 5;
	localparam int div_cycles  = 10;

	//////////////////////////////////////////////////
	// Operation codes
	//////////////////////////////////////////////////

	typedef enum logic [4:0] {
		op_add, op_sub, op_and, op_or, op_xor, op_nor, op_slt, op_sltu,
		op_sll, op_srl, op_sra, op_sllv, op_srlv, op_srav,
		op_mult, op_multu, op_div, op_divu,
		op_mthi, op_mtlo, op_mfhi, op_mflo,
		op_illegal
	} exec_op_e;

	//////////////////////////////////////////////////
	// Stream payloads
	//////////////////////////////////////////////////

	// Raw input beat, instruction plus both register values
	typedef struct packed {
		logic [data_width-1:0] instr;
		logic [data_width-1:0] rs_val;
		logic [data_width-1:0] rt_val;
	} instr_beat_t;

	// Decoded operation as queued for the execute unit
	typedef struct packed {
		exec_op_e              op;
		logic [4:0]            shamt;
		logic [data_width-1:0] a;
		logic [data_width-1:0] b;
		logic                  writes_result;
	} exec_op_t;

	typedef struct packed {
		logic [data_width-1:0] value;
		logic                  overflow;
	} exec_result_t;

endpackage

`default_nettype wire

// File: design/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import exec_pkg::*; (
	input  exec_op_e              op,
	input  logic [data_width-1:0] a,
	input  logic [data_width-1:0] b,
	input  logic [4:0]            shamt,
	output logic [data_width-1:0] result,
	output logic                  overflow
);

	logic [data_width:0] add_ext;
	logic [data_width:0] sub_ext;

	// One extra sign bit, overflow when the top two bits differ
	assign add_ext = {a[data_width-1], a} + {b[data_width-1], b};
	assign sub_ext = {a[data_width-1], a} - {b[data_width-1], b};

	always_comb begin
		case (op)
			op_add:  overflow = add_ext[data_width] != add_ext[data_width-1];
			op_sub:  overflow = sub_ext[data_width] != sub_ext[data_width-1];
			default: overflow = 1'b0;
		endcase
	end

	always_comb begin
		case (op)
			op_add:  result = add_ext[data_width-1:0];
			op_sub:  result = sub_ext[data_width-1:0];
			op_and:  result = a & b;
			op_or:   result = a | b;
			op_xor:  result = a ^ b;
			op_nor:  result = ~(a | b);
			op_slt:  result = data_width'($signed(a) < $signed(b));
			op_sltu: result = data_width'(a < b);
			// Shift by the instruction field
			op_sll:  result = b << shamt;
			op_srl:  result = b >> shamt;
			op_sra:  result = $signed(b) >>> shamt;
			// Shift by the low bits of rs
			op_sllv: result = b << a[4:0];
			op_srlv: result = b >> a[4:0];
			op_srav: result = $signed(b) >>> a[4:0];
			default: result = '1;
		endcase
	end

endmodule

`default_nettype wire

// File: design/muldiv_unit.sv
`timescale 1ns/1ps
`default_nettype none

module muldiv_unit import exec_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  exec_op_e              op,
	input  logic [data_width-1:0] a,
	input  logic [data_width-1:0] b,
	input  logic                  start,
	output logic                  busy,
	output logic [data_width-1:0] hi,
	output logic [data_width-1:0] lo
);

	localparam int cnt_w = $clog2(div_cycles);

	logic [data_width-1:0]   hi_stage;
	logic [data_width-1:0]   lo_stage;
	logic [cnt_w-1:0]        count;
	logic [2*data_width-1:0] prod_s;
	logic [2*data_width-1:0] prod_u;
	logic [data_width-1:0]   quot_s;
	logic [data_width-1:0]   rem_s;
	logic [data_width-1:0]   quot_u;
	logic [data_width-1:0]   rem_u;
	logic                    div_zero;
	logic                    div_ovf;

	assign prod_s = $signed(a) * $signed(b);
	assign prod_u = a * b;

	assign div_zero = b == '0;
	assign div_ovf  = (a == {1'b1, {(data_width-1){1'b0}}}) && (b == '1);

	//////////////////////////////////////////////////
	// Divider with the corner cases pinned down
	//////////////////////////////////////////////////

	always_comb begin
		if (div_zero) begin
			quot_s = '1;
			rem_s  = a;
			quot_u = '1;
			rem_u  = a;
		end else begin
			quot_u = a / b;
			rem_u  = a % b;
			if (div_ovf) begin
				// Min over minus one wraps back to min
				quot_s = a;
				rem_s  = '0;
			end else begin
				quot_s = $signed(a) / $signed(b);
				rem_s  = $signed(a) % $signed(b);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			case (op)
				op_mult:  {hi_stage, lo_stage} <= prod_s;
				op_multu: {hi_stage, lo_stage} <= prod_u;
				op_div:   {hi_stage, lo_stage} <= {rem_s, quot_s};
				op_divu:  {hi_stage, lo_stage} <= {rem_u, quot_u};
				default:  {hi_stage, lo_stage} <= {hi_stage, lo_stage};
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Busy countdown and HI/LO update
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			busy  <= 1'b0;
			count <= '0;
			hi    <= '0;
			lo    <= '0;
		end else if (start) begin
			case (op)
				op_mult, op_multu: begin
					busy  <= 1'b1;
					count <= cnt_w'(mult_cycles - 1);
				end
				op_div, op_divu: begin
					busy  <= 1'b1;
					count <= cnt_w'(div_cycles - 1);
				end
				op_mthi: hi <= a;
				op_mtlo: lo <= a;
				default: busy <= busy;
			endcase
		end else if (busy) begin
			if (count == '0) begin
				busy <= 1'b0;
				hi   <= hi_stage;
				lo   <= lo_stage;
			end else begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: design/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder import exec_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  instr_beat_t in_beat,
	input  logic        in_valid,
	output logic        in_ready,
	output exec_op_t    op,
	output logic        op_valid,
	input  logic        op_ready
);

	logic [5:0] opcode;
	logic [5:0] funct;
	exec_op_t   dec_op;

	assign opcode = in_beat.instr[31:26];
	assign funct  = in_beat.instr[5:0];

	// Stage is free when empty or when its content leaves this cycle
	assign in_ready = !op_valid || op_ready;

	always_comb begin
		dec_op.shamt = in_beat.instr[10:6];
		dec_op.a = in_beat.rs_val;
		dec_op.b = in_beat.rt_val;
		dec_op.op = op_illegal;
		if (opcode == 6'h00) begin
			case (funct)
				6'h00: dec_op.op = op_sll;
				6'h02: dec_op.op = op_srl;
				6'h03: dec_op.op = op_sra;
				6'h04: dec_op.op = op_sllv;
				6'h06: dec_op.op = op_srlv;
				6'h07: dec_op.op = op_srav;
				6'h10: dec_op.op = op_mfhi;
				6'h11: dec_op.op = op_mthi;
				6'h12: dec_op.op = op_mflo;
				6'h13: dec_op.op = op_mtlo;
				6'h18: dec_op.op = op_mult;
				6'h19: dec_op.op = op_multu;
				6'h1a: dec_op.op = op_div;
				6'h1b: dec_op.op = op_divu;
				6'h20: dec_op.op = op_add;
				6'h22: dec_op.op = op_sub;
				6'h24: dec_op.op = op_and;
				6'h25: dec_op.op = op_or;
				6'h26: dec_op.op = op_xor;
				6'h27: dec_op.op = op_nor;
				6'h2a: dec_op.op = op_slt;
				6'h2b: dec_op.op = op_sltu;
				default: dec_op.op = op_illegal;
			endcase
		end
		// HI/LO writers and mult/div leave no result beat
		dec_op.writes_result = !(dec_op.op inside {op_mult, op_multu, op_div, op_divu,
			op_mthi, op_mtlo});
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			op_valid <= 1'b0;
		end else if (in_ready) begin
			op_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			op <= dec_op;
		end
	end

endmodule

`default_nettype wire

// File: design/op_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module op_fifo import exec_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  exec_op_t wr_op,
	input  logic     wr_valid,
	output logic     wr_ready,
	output exec_op_t rd_op,
	output logic     rd_valid,
	input  logic     rd_ready
);

	localparam int ptr_w   = $clog2(fifo_depth);
	localparam int count_w = $clog2(fifo_depth + 1);

	exec_op_t           mem [fifo_depth];
	logic [ptr_w-1:0]   wr_ptr;
	logic [ptr_w-1:0]   rd_ptr;
	logic [count_w-1:0] count;
	logic               do_wr;
	logic               do_rd;

	assign wr_ready = count != count_w'(fifo_depth);
	assign rd_valid = count != '0;
	assign rd_op    = mem[rd_ptr];

	assign do_wr = wr_valid && wr_ready;
	assign do_rd = rd_valid && rd_ready;

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_op;
		end
	end

	// Pointers wrap at fifo_depth
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit import exec_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  exec_op_t     op,
	input  logic         op_valid,
	output logic         op_ready,
	output exec_result_t out_result,
	output logic         out_valid,
	input  logic         out_ready
);

	logic                  accept;
	logic                  busy;
	logic [data_width-1:0] hi;
	logic [data_width-1:0] lo;
	logic [data_width-1:0] alu_result;
	logic                  alu_overflow;
	exec_result_t          next_result;

	// Hold off while mult/div runs or the result slot is stuck
	assign op_ready = !busy && (!out_valid || out_ready);
	assign accept   = op_valid && op_ready;

	alu u_alu (
		.op       (op.op),
		.a        (op.a),
		.b        (op.b),
		.shamt    (op.shamt),
		.result   (alu_result),
		.overflow (alu_overflow)
	);

	// Every non-writing op belongs to the HI/LO side
	muldiv_unit u_muldiv (
		.clk   (clk),
		.reset (reset),
		.op    (op.op),
		.a     (op.a),
		.b     (op.b),
		.start (accept && !op.writes_result),
		.busy  (busy),
		.hi    (hi),
		.lo    (lo)
	);

	always_comb begin
		case (op.op)
			op_mfhi: next_result = '{value: hi, overflow: 1'b0};
			op_mflo: next_result = '{value: lo, overflow: 1'b0};
			default: next_result = '{value: alu_result, overflow: alu_overflow};
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (accept && op.writes_result) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept && op.writes_result) begin
			out_result <= next_result;
		end
	end

endmodule

`default_nettype wire

// File: design/mips_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module mips_exec_top import exec_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  instr_beat_t  in_beat,
	input  logic         in_valid,
	output logic         in_ready,
	output exec_result_t out_result,
	output logic         out_valid,
	input  logic         out_ready
);

	// Decoder to FIFO
	exec_op_t dec_op;
	logic     dec_valid;
	logic     dec_ready;

	// FIFO to execute unit
	exec_op_t q_op;
	logic     q_valid;
	logic     q_ready;

	instr_decoder u_decoder (
		.clk      (clk),
		.reset    (reset),
		.in_beat  (in_beat),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.op       (dec_op),
		.op_valid (dec_valid),
		.op_ready (dec_ready)
	);

	op_fifo u_fifo (
		.clk      (clk),
		.reset    (reset),
		.wr_op    (dec_op),
		.wr_valid (dec_valid),
		.wr_ready (dec_ready),
		.rd_op    (q_op),
		.rd_valid (q_valid),
		.rd_ready (q_ready)
	);

	exec_unit u_exec (
		.clk        (clk),
		.reset      (reset),
		.op         (q_op),
		.op_valid   (q_valid),
		.op_ready   (q_ready),
		.out_result (out_result),
		.out_valid  (out_valid),
		.out_ready  (out_ready)
	);

endmodule

`default_nettype wire

// File: tb/mips_exec_properties.sv
`timescale 1ns/1ps
`default_nettype none

module mips_exec_properties import exec_pkg::*; (
	input logic         clk,
	input logic         reset,
	input instr_beat_t  in_beat,
	input logic         in_valid,
	input logic         in_ready,
	input exec_result_t out_result,
	input logic         out_valid,
	input logic         out_ready,
	input exec_op_t     op,
	input logic         op_valid,
	input logic         busy
);

	// Stalled beats keep valid and payload
	in_stable: assert property (@(posedge clk) disable iff (reset)
		in_valid && !in_ready |=> in_valid && $stable(in_beat))
		else $error("input beat changed before it was taken");

	out_stable: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_result))
		else $error("result beat changed before it was taken");

	// Queue head waits untouched while mult/div runs
	no_issue_busy: assert property (@(posedge clk) disable iff (reset)
		busy && op_valid |=> op_valid && $stable(op))
		else $error("operation taken from the queue while mult/div busy");

	busy_bounded: assert property (@(posedge clk) disable iff (reset)
		$rose(busy) |-> ##[1:div_cycles] !busy)
		else $error("busy held longer than the divide latency");

endmodule

bind mips_exec_top mips_exec_properties u_props (
	.clk        (clk),
	.reset      (reset),
	.in_beat    (in_beat),
	.in_valid   (in_valid),
	.in_ready   (in_ready),
	.out_result (out_result),
	.out_valid  (out_valid),
	.out_ready  (out_ready),
	.op         (u_exec.op),
	.op_valid   (u_exec.op_valid),
	.busy       (u_exec.busy)
);

`default_nettype wire

// File: tb/tb_mips_exec.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_exec import exec_pkg::*; ();

	localparam int clk_period      = 40;
	localparam int reset_cycles    = 8;
	localparam int n_random        = 400;
	localparam int n_directed_max  = 48;
	localparam int stall_allowance = 8;
	localparam longint watchdog_ns = longint'(n_random + n_directed_max)
		* (div_cycles + fifo_depth + stall_allowance) * clk_period;

	logic         clk;
	logic         reset;
	instr_beat_t  in_beat;
	logic         in_valid;
	logic         in_ready;
	exec_result_t out_result;
	logic         out_valid;
	logic         out_ready;
	logic         hold_output;

	logic [31:0]  lfsr_state = 32'hc795;
	logic [31:0]  model_hi = '0;
	logic [31:0]  model_lo = '0;
	exec_result_t expected [$];
	int           results_seen = 0;
	int           value_errors = 0;
	int           overflow_errors = 0;
	int           other_errors = 0;

	// Weighted pick, extra HI/LO reads and two illegal slots
	exec_op_e kind_table [32] = '{
		op_add, op_sub, op_and, op_or, op_xor, op_nor, op_slt, op_sltu,
		op_sll, op_srl, op_sra, op_sllv, op_srlv, op_srav,
		op_mult, op_multu, op_div, op_divu, op_mthi, op_mtlo, op_mfhi, op_mflo,
		op_mfhi, op_mflo, op_mfhi, op_mflo, op_add, op_sub, op_mult, op_div,
		op_illegal, op_illegal
	};

	mips_exec_top dut (
		.clk        (clk),
		.reset      (reset),
		.in_beat    (in_beat),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.out_result (out_result),
		.out_valid  (out_valid),
		.out_ready  (out_ready)
	);

	always #(clk_period / 2) clk = ~clk;

	//////////////////////////////////////////////////
	// Random source
	//////////////////////////////////////////////////

	// Galois LFSR, one step per output bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic        lsb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lsb = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (lsb) begin
				lfsr_state = lfsr_state ^ 32'h8020_0003;
			end
			v = {v[30:0], lsb};
		end
		return v;
	endfunction

	function automatic logic [31:0] pick_operand();
		logic [3:0] sel;
		sel = 4'(rand_bits(4));
		case (sel)
			4'd0:    return 32'h0000_0000;
			4'd1:    return 32'hffff_ffff;
			4'd2:    return 32'h8000_0000;
			default: return rand_bits(32);
		endcase
	endfunction

	//////////////////////////////////////////////////
	// Instruction encoding
	//////////////////////////////////////////////////

	function automatic logic [5:0] funct_of(input exec_op_e kind);
		case (kind)
			op_sll:   return 6'h00;
			op_srl:   return 6'h02;
			op_sra:   return 6'h03;
			op_sllv:  return 6'h04;
			op_srlv:  return 6'h06;
			op_srav:  return 6'h07;
			op_mfhi:  return 6'h10;
			op_mthi:  return 6'h11;
			op_mflo:  return 6'h12;
			op_mtlo:  return 6'h13;
			op_mult:  return 6'h18;
			op_multu: return 6'h19;
			op_div:   return 6'h1a;
			op_divu:  return 6'h1b;
			op_add:   return 6'h20;
			op_sub:   return 6'h22;
			op_and:   return 6'h24;
			op_or:    return 6'h25;
			op_xor:   return 6'h26;
			op_nor:   return 6'h27;
			op_slt:   return 6'h2a;
			op_sltu:  return 6'h2b;
			default:  return 6'h3f;
		endcase
	endfunction

	// Illegal either by a non-special opcode or an unused funct
	function automatic instr_beat_t encode(input exec_op_e kind, input logic [4:0] shamt,
		input logic [31:0] rs_val, input logic [31:0] rt_val);
		instr_beat_t beat;
		logic [5:0]  opcode;
		logic [5:0]  funct;
		logic [1:0]  sel;
		opcode = 6'h00;
		funct  = funct_of(kind);
		if (kind == op_illegal) begin
			sel = 2'(rand_bits(2));
			case (sel)
				2'd0: begin
					opcode = 6'(rand_bits(5)) | 6'h01;
					funct  = 6'(rand_bits(6));
				end
				2'd1:    funct = 6'h01;
				2'd2:    funct = 6'h0c;
				default: funct = 6'h3f;
			endcase
		end
		beat.instr  = {opcode, 5'd1, 5'd2, 5'd3, shamt, funct};
		beat.rs_val = rs_val;
		beat.rt_val = rt_val;
		return beat;
	endfunction

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	function automatic logic [31:0] shift_right_arith(input logic [31:0] val,
		input logic [4:0] sh);
		logic [31:0] fill;
		fill = val[31] ? ~(32'hffff_ffff >> sh) : 32'h0;
		return (val >> sh) | fill;
	endfunction

	task automatic model_issue(input exec_op_e kind, input instr_beat_t beat);
		logic [31:0]  a;
		logic [31:0]  b;
		logic [31:0]  v;
		logic [4:0]   sh;
		logic         ovf;
		logic         writes;
		logic [63:0]  wide;
		longint       sa;
		longint       sb;
		exec_result_t res;
		a      = beat.rs_val;
		b      = beat.rt_val;
		sh     = beat.instr[10:6];
		v      = 32'hffff_ffff;
		ovf    = 1'b0;
		writes = 1'b1;
		sa     = longint'($signed(a));
		sb     = longint'($signed(b));
		case (kind)
			op_add: begin
				v   = a + b;
				ovf = (a[31] == b[31]) && (v[31] != a[31]);
			end
			op_sub: begin
				v   = a - b;
				ovf = (a[31] != b[31]) && (v[31] != a[31]);
			end
			op_and:  v = a & b;
			op_or:   v = a | b;
			op_xor:  v = a ^ b;
			op_nor:  v = ~(a | b);
			op_slt:  v = {31'b0, sa < sb};
			op_sltu: v = {31'b0, a < b};
			op_sll:  v = b << sh;
			op_srl:  v = b >> sh;
			op_sra:  v = shift_right_arith(b, sh);
			op_sllv: v = b << a[4:0];
			op_srlv: v = b >> a[4:0];
			op_srav: v = shift_right_arith(b, a[4:0]);
			op_mult: begin
				wide = 64'(sa * sb);
				{model_hi, model_lo} = wide;
				writes = 1'b0;
			end
			op_multu: begin
				wide = {32'b0, a} * {32'b0, b};
				{model_hi, model_lo} = wide;
				writes = 1'b0;
			end
			// Wide signed math also covers min over minus one
			op_div: begin
				if (b == '0) begin
					model_hi = a;
					model_lo = 32'hffff_ffff;
				end else begin
					model_hi = 32'(sa % sb);
					model_lo = 32'(sa / sb);
				end
				writes = 1'b0;
			end
			op_divu: begin
				if (b == '0) begin
					model_hi = a;
					model_lo = 32'hffff_ffff;
				end else begin
					model_hi = a % b;
					model_lo = a / b;
				end
				writes = 1'b0;
			end
			op_mthi: begin
				model_hi = a;
				writes   = 1'b0;
			end
			op_mtlo: begin
				model_lo = a;
				writes   = 1'b0;
			end
			op_mfhi: v = model_hi;
			op_mflo: v = model_lo;
			default: v = 32'hffff_ffff;
		endcase
		if (writes) begin
			res.value    = v;
			res.overflow = ovf;
			expected.push_back(res);
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	// Called at a falling edge, returns at the falling edge after the transfer
	task automatic send_beat(input exec_op_e kind, input instr_beat_t beat);
		in_beat  = beat;
		in_valid = 1'b1;
		#1;
		while (!in_ready) begin
			@(negedge clk);
			#1;
		end
		model_issue(kind, beat);
		@(negedge clk);
	endtask

	task automatic send_op(input exec_op_e kind, input logic [31:0] a, input logic [31:0] b);
		logic [4:0] sh;
		sh = 5'(rand_bits(5));
		send_beat(kind, encode(kind, sh, a, b));
	endtask

	task automatic read_hilo();
		send_op(op_mfhi, 32'h0, 32'h0);
		send_op(op_mflo, 32'h0, 32'h0);
	endtask

	task automatic send_random();
		exec_op_e    kind;
		logic [4:0]  sh;
		logic [31:0] a;
		logic [31:0] b;
		kind = kind_table[rand_bits(5)];
		sh   = 5'(rand_bits(5));
		a    = pick_operand();
		b    = pick_operand();
		send_beat(kind, encode(kind, sh, a, b));
	endtask

	// Ready decided at the rising edge, applied at the falling edge
	initial begin
		logic next_ready;
		out_ready = 1'b0;
		forever begin
			@(posedge clk);
			next_ready = !hold_output && (rand_bits(2) != 32'd0);
			@(negedge clk);
			out_ready = next_ready;
		end
	end

	//////////////////////////////////////////////////
	// Scoreboard
	//////////////////////////////////////////////////

	task automatic check_output();
		exec_result_t exp;
		if (expected.size() == 0) begin
			other_errors++;
			$display("Result beat appeared with no instruction left to account for it");
		end else begin
			exp = expected.pop_front();
			results_seen++;
			assert (out_result.value == exp.value) else begin
				value_errors++;
				$display("** Error: out_result.value = %h, expected %h",
					out_result.value, exp.value);
			end
			assert (out_result.overflow == exp.overflow) else begin
				overflow_errors++;
				$display("** Error: out_result.overflow = %h, expected %h (value %h)",
					out_result.overflow, exp.overflow, exp.value);
			end
		end
	endtask

	always @(negedge clk) begin
		#2;
		if (!reset && out_valid && out_ready) begin
			check_output();
		end
	end

	initial begin
		#(watchdog_ns);
		$display("Timeout after %0d ns with %0d results still outstanding",
			watchdog_ns, expected.size());
		$display("Checks failed");
		$finish;
	end

	initial begin
		clk         = 1'b0;
		reset       = 1'b1;
		in_valid    = 1'b0;
		in_beat     = '0;
		hold_output = 1'b0;
		repeat (reset_cycles) @(negedge clk);
		reset = 1'b0;
		assert (!out_valid && in_ready) else begin
			other_errors++;
			$display("Pipeline not idle after reset");
		end

		// HI/LO after reset, then direct writes
		read_hilo();
		send_op(op_mthi, 32'h1234_5678, 32'h0);
		send_op(op_mtlo, 32'hcafe_f00d, 32'h0);
		read_hilo();

		// Divide corners and multiplies
		send_op(op_div, 32'h8000_0000, 32'hffff_ffff);
		read_hilo();
		send_op(op_div, 32'h0000_1234, 32'h0);
		read_hilo();
		send_op(op_divu, 32'hdead_beef, 32'h0);
		read_hilo();
		send_op(op_div, 32'hffff_fff9, 32'h0000_0002);
		read_hilo();
		send_op(op_mult, 32'hffff_fffe, 32'h0000_0003);
		read_hilo();
		send_op(op_multu, 32'hffff_ffff, 32'hffff_ffff);
		read_hilo();
		send_op(op_add, 32'h7fff_ffff, 32'h0000_0001);
		send_op(op_sub, 32'h8000_0000, 32'h0000_0001);
		send_op(op_add, 32'hffff_ffff, 32'h0000_0001);

		// Hold the output until the whole pipeline backs up
		hold_output = 1'b1;
		fork
			begin
				repeat (fifo_depth + 6) send_op(op_or, pick_operand(), pick_operand());
			end
			begin
				repeat (20) @(negedge clk);
				#1;
				assert (!in_ready) else begin
					other_errors++;
					$display("in_ready stayed high while the output was held back");
				end
				hold_output = 1'b0;
			end
		join

		for (int i = 0; i < n_random; i++) begin
			if (rand_bits(2) == 32'd0) begin
				in_valid = 1'b0;
				repeat (1 + rand_bits(2)) @(negedge clk);
			end
			send_random();
		end
		in_valid = 1'b0;

		while (expected.size() != 0) begin
			@(negedge clk);
		end
		// Quiet tail catches any extra beat
		repeat (div_cycles + fifo_depth) @(negedge clk);

		$display("Results %0d, value errors %0d, overflow errors %0d, other errors %0d",
			results_seen, value_errors, overflow_errors, other_errors);
		if (value_errors + overflow_errors + other_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: mips_exec.f
design/exec_pkg.sv
design/alu.sv
design/muldiv_unit.sv
design/instr_decoder.sv
design/op_fifo.sv
design/exec_unit.sv
design/mips_exec_top.sv
tb/mips_exec_properties.sv
tb/tb_mips_exec.sv

// File: Bender.yml
package:
  name: mips_exec

sources:
  - design/exec_pkg.sv
  - design/alu.sv
  - design/muldiv_unit.sv
  - design/instr_decoder.sv
  - design/op_fifo.sv
  - design/exec_unit.sv
  - design/mips_exec_top.sv
  - target: test
    files:
      - tb/mips_exec_properties.sv
      - tb/tb_mips_exec.sv
